//--- include/axi_bram_settings.svh
////////////////////////////////////////
// AXI block RAM settings
// Sizes shared by the package and the
// RTL of the memory-mapped RAM slave
////////////////////////////////////////

`ifndef AXI_BRAM_SETTINGS_SVH
`define AXI_BRAM_SETTINGS_SVH

// Number of 32-bit words held in the RAM
`define BRAM_DEPTH 1024

// Byte address width on the AXI side
`define BRAM_ADDR_WIDTH 32

// Transaction ID width
`define BRAM_ID_WIDTH 4

`endif

//--- src/axi_pkg.sv
////////////////////////////////////////
// AXI package
// Vector types and encodings shared by
// the block RAM slave and its RAM
////////////////////////////////////////

`default_nettype none

`include "axi_bram_settings.svh"

package axi_pkg;

    typedef logic [`BRAM_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [31:0]                 axi_data_t;
    typedef logic [3:0]                  axi_strb_t;
    typedef logic [`BRAM_ID_WIDTH-1:0]   axi_id_t;
    // Burst length minus one
    typedef logic [7:0]                  axi_len_t;
    typedef logic [2:0]                  axi_size_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        EXOKAY = 2'd1,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } axi_resp_e;

    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } axi_burst_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ
    } bram_state_e;

endpackage

`default_nettype wire

//--- src/mem_1rwm.sv
////////////////////////////////////////
// Single-port word RAM
// One read-or-write port, byte write
// enables, registered read data
////////////////////////////////////////

`default_nettype none

module mem_1rwm
    import axi_pkg::*;
#(
    parameter int ADDR_BITS = 10
) (
    input  wire logic           clk,
    input  wire logic [ADDR_BITS-1:0] address,
    input  wire logic           read,
    input  wire logic           write,
    input  wire axi_strb_t      writeenable,
    input  wire axi_data_t      writedata,
    output axi_data_t           readdata
);

    axi_data_t storage [2**ADDR_BITS];

    // Byte lanes are written only under their enable bit
    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (writeenable[lane]) begin
                    storage[address][lane*8 +: 8] <= writedata[lane*8 +: 8];
                end
            end
        end
    end

    // Output holds between reads, so data stays put while the bus stalls
    always_ff @(posedge clk) begin
        if (read) begin
            readdata <= storage[address];
        end
    end

    // One port only
    a_single_access: assert property (@(posedge clk) !(read && write));

endmodule

`default_nettype wire

//--- src/axi_burst_addr.sv
////////////////////////////////////////
// AXI burst address step
// Next beat address for INCR and WRAP
// bursts, plus range decode of an
// address into OKAY or DECERR
////////////////////////////////////////

`default_nettype none

`include "axi_bram_settings.svh"

module axi_burst_addr
    import axi_pkg::*;
(
    input  wire axi_addr_t  addr,
    input  wire axi_burst_e burst,
    input  wire axi_len_t   len,
    output axi_addr_t       next_addr,
    input  wire axi_addr_t  check_addr,
    output axi_resp_e       resp
);

    // Byte size of the RAM and first address that decodes to nothing
    localparam axi_addr_t RAM_BYTES = axi_addr_t'(`BRAM_DEPTH * 4);

    axi_addr_t incr_addr;
    axi_addr_t wrap_mask;

    // Every beat is a full word
    assign incr_addr = addr + axi_addr_t'(4);

    // Low address bits that change inside one wrap block
    // len 1 -> 3'b111, len 3 -> 4'b1111, len 7 -> 5'b11111
    assign wrap_mask = (axi_addr_t'(len) << 2) | axi_addr_t'(3);

    always_comb begin
        case (burst)
            INCR:    next_addr = incr_addr;
            WRAP:    next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
            // FIXED keeps the same location
            default: next_addr = addr;
        endcase
    end

    assign resp = (check_addr < RAM_BYTES) ? OKAY : DECERR;

endmodule

`default_nettype wire

//--- src/axi_bram.sv
////////////////////////////////////////
// AXI4 block RAM slave
// Serves one transaction at a time with
// single-beat writes and INCR or WRAP
// read bursts of up to 256 beats
// Addresses beyond the RAM answer DECERR
////////////////////////////////////////

`default_nettype none

`include "axi_bram_settings.svh"

module axi_bram
    import axi_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,

    // Write address channel
    input  wire logic       awvalid,
    output logic            awready,
    input  wire axi_addr_t  awaddr,
    input  wire axi_len_t   awlen,
    input  wire axi_size_t  awsize,
    input  wire axi_burst_e awburst,
    input  wire axi_id_t    awid,

    // Write data channel
    input  wire logic       wvalid,
    output logic            wready,
    input  wire axi_data_t  wdata,
    input  wire axi_strb_t  wstrb,
    input  wire logic       wlast,

    // Write response channel
    output logic            bvalid,
    input  wire logic       bready,
    output axi_resp_e       bresp,
    output axi_id_t         bid,

    // Read address channel
    input  wire logic       arvalid,
    output logic            arready,
    input  wire axi_addr_t  araddr,
    input  wire axi_len_t   arlen,
    input  wire axi_size_t  arsize,
    input  wire axi_burst_e arburst,
    input  wire axi_id_t    arid,

    // Read data channel
    output logic            rvalid,
    input  wire logic       rready,
    output axi_data_t       rdata,
    output axi_resp_e       rresp,
    output logic            rlast,
    output axi_id_t         rid
);

    localparam int WORD_BITS = $clog2(`BRAM_DEPTH);

    bram_state_e state_q;
    bram_state_e state_d;
    logic        bvalid_d;
    logic        rvalid_d;

    // Transaction context captured at the address phase
    axi_addr_t   addr_q;
    axi_id_t     id_q;
    axi_resp_e   resp_q;
    axi_burst_e  burst_q;
    axi_len_t    len_q;
    axi_len_t    remaining_q;

    axi_addr_t   next_addr;
    axi_addr_t   check_addr;
    axi_resp_e   check_resp;

    logic        mem_read;
    logic        mem_write;
    axi_addr_t   mem_addr;
    logic        read_step;

    ////////////////////////////////////////
    // RAM and address arithmetic
    ////////////////////////////////////////

    mem_1rwm #(
        .ADDR_BITS  (WORD_BITS)
    ) u_mem (
        .clk        (clk),
        .address    (mem_addr[WORD_BITS+1:2]),
        .read       (mem_read),
        .write      (mem_write),
        .writeenable(wstrb),
        .writedata  (wdata),
        .readdata   (rdata)
    );

    // Idle decodes the incoming address and a burst decodes its next beat
    assign check_addr = (state_q != IDLE) ? next_addr :
                        (awvalid ? awaddr : araddr);

    axi_burst_addr u_burst_addr (
        .addr       (addr_q),
        .burst      (burst_q),
        .len        (len_q),
        .next_addr  (next_addr),
        .check_addr (check_addr),
        .resp       (check_resp)
    );

    ////////////////////////////////////////
    // Channel sequencing
    ////////////////////////////////////////

    always_comb begin
        state_d   = state_q;
        bvalid_d  = bvalid;
        rvalid_d  = rvalid;
        awready   = 1'b0;
        arready   = 1'b0;
        wready    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        mem_addr  = addr_q;
        read_step = 1'b0;

        case (state_q)
            IDLE: begin
                // Write wins when both address channels are valid
                if (awvalid) begin
                    awready = 1'b1;
                    state_d = WRITE;
                end else if (arvalid) begin
                    arready  = 1'b1;
                    mem_read = 1'b1;
                    mem_addr = araddr;
                    rvalid_d = 1'b1;
                    state_d  = READ;
                end
            end
            WRITE: begin
                wready = 1'b1;
                if (wvalid) begin
                    // Out of range writes are answered but dropped
                    mem_write = (resp_q == OKAY);
                    bvalid_d  = 1'b1;
                    state_d   = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    bvalid_d = 1'b0;
                    state_d  = IDLE;
                end
            end
            READ: begin
                if (rready) begin
                    if (rlast) begin
                        rvalid_d = 1'b0;
                        state_d  = IDLE;
                    end else begin
                        // Prefetch the following beat
                        read_step = 1'b1;
                        mem_read  = 1'b1;
                        mem_addr  = next_addr;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= IDLE;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            state_q <= state_d;
            bvalid  <= bvalid_d;
            rvalid  <= rvalid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addr_q <= awaddr;
            id_q   <= awid;
            resp_q <= check_resp;
        end else if (arvalid && arready) begin
            addr_q      <= araddr;
            id_q        <= arid;
            resp_q      <= check_resp;
            burst_q     <= arburst;
            len_q       <= arlen;
            remaining_q <= arlen;
        end else if (read_step) begin
            addr_q      <= next_addr;
            resp_q      <= check_resp;
            remaining_q <= remaining_q - axi_len_t'(1);
        end
    end

    assign bresp = resp_q;
    assign bid   = id_q;
    assign rresp = resp_q;
    assign rid   = id_q;
    assign rlast = (state_q == READ) && (remaining_q == '0);

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////

    // Only aligned full-word single-beat INCR writes are supported
    a_aw_format: assert property (@(posedge clk) disable iff (rst_n)
        (awvalid && awready) |->
            (awaddr[1:0] == 2'b00) && (awsize == 3'd2) &&
            (awlen == '0) && (awburst == INCR));

    a_w_last: assert property (@(posedge clk) disable iff (rst_n)
        (wvalid && wready) |-> wlast);

    a_ar_format: assert property (@(posedge clk) disable iff (rst_n)
        (arvalid && arready) |->
            (araddr[1:0] == 2'b00) && (arsize == 3'd2) &&
            ((arburst == INCR) || (arburst == WRAP)));

    // A stalled beat must not be withdrawn or changed
    a_r_hold: assert property (@(posedge clk) disable iff (rst_n)
        (rvalid && !rready) |=>
            rvalid && $stable(rdata) && $stable(rresp) &&
            $stable(rlast) && $stable(rid));

endmodule

`default_nettype wire

//--- src/axi_bram_top.sv
////////////////////////////////////////
// AXI block RAM top level
// Exposes the AXI4 slave ports of the
// RAM slave
////////////////////////////////////////

`default_nettype none

module axi_bram_top
    import axi_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,

    input  wire logic       awvalid,
    output logic            awready,
    input  wire axi_addr_t  awaddr,
    input  wire axi_len_t   awlen,
    input  wire axi_size_t  awsize,
    input  wire axi_burst_e awburst,
    input  wire axi_id_t    awid,

    input  wire logic       wvalid,
    output logic            wready,
    input  wire axi_data_t  wdata,
    input  wire axi_strb_t  wstrb,
    input  wire logic       wlast,

    output logic            bvalid,
    input  wire logic       bready,
    output axi_resp_e       bresp,
    output axi_id_t         bid,

    input  wire logic       arvalid,
    output logic            arready,
    input  wire axi_addr_t  araddr,
    input  wire axi_len_t   arlen,
    input  wire axi_size_t  arsize,
    input  wire axi_burst_e arburst,
    input  wire axi_id_t    arid,

    output logic            rvalid,
    input  wire logic       rready,
    output axi_data_t       rdata,
    output axi_resp_e       rresp,
    output logic            rlast,
    output axi_id_t         rid
);

    axi_bram u_bram (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awid    (awid),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .bid     (bid),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arid    (arid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rid     (rid)
    );

endmodule

`default_nettype wire

//--- tb/axi_bram_tb.sv
////////////////////////////////////////
// AXI block RAM testbench
// Runs a table of writes and read
// bursts against a reference memory,
// with random bready and rready stalls
////////////////////////////////////////

`default_nettype none

module axi_bram_tb
    import axi_pkg::*;
();

    localparam int   NUM_ENTRIES = 17;
    localparam int   CLK_PERIOD  = 40;
    localparam logic OP_WR       = 1'b1;
    localparam logic OP_RD       = 1'b0;

    typedef struct {
        logic       is_write;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_burst_e burst;
        axi_data_t  data;
        axi_strb_t  strb;
        axi_id_t    id;
        axi_resp_e  resp;
    } entry_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       awvalid;
    logic       awready;
    axi_addr_t  awaddr;
    axi_len_t   awlen;
    axi_size_t  awsize;
    axi_burst_e awburst;
    axi_id_t    awid;
    logic       wvalid;
    logic       wready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    axi_resp_e  bresp;
    axi_id_t    bid;
    logic       arvalid;
    logic       arready;
    axi_addr_t  araddr;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_e arburst;
    axi_id_t    arid;
    logic       rvalid;
    logic       rready;
    axi_data_t  rdata;
    axi_resp_e  rresp;
    logic       rlast;
    axi_id_t    rid;

    entry_t     tests [NUM_ENTRIES];
    int         num_loaded = 0;
    int         errors = 0;
    integer     seed = 44438;
    // Expected RAM contents keyed by byte address
    axi_data_t  model [axi_addr_t];

    axi_bram_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic add_entry(input logic is_write, input axi_addr_t addr, input axi_len_t len,
                             input axi_burst_e burst, input axi_data_t data,
                             input axi_strb_t strb, input axi_id_t id, input axi_resp_e resp);
        tests[num_loaded].is_write = is_write;
        tests[num_loaded].addr     = addr;
        tests[num_loaded].len      = len;
        tests[num_loaded].burst    = burst;
        tests[num_loaded].data     = data;
        tests[num_loaded].strb     = strb;
        tests[num_loaded].id       = id;
        tests[num_loaded].resp     = resp;
        num_loaded++;
    endtask

    task automatic load_tests();
        // Full word written and read back
        add_entry(OP_WR, 32'h0000_0000, 8'd0, INCR, 32'hDEAD_BEEF, 4'hF, 4'h1, OKAY);
        add_entry(OP_RD, 32'h0000_0000, 8'd0, INCR, 32'h0000_0000, 4'h0, 4'h2, OKAY);
        // Byte lanes 0 and 2 only
        add_entry(OP_WR, 32'h0000_0010, 8'd0, INCR, 32'h1122_3344, 4'hF, 4'h3, OKAY);
        add_entry(OP_WR, 32'h0000_0010, 8'd0, INCR, 32'hAABB_CCDD, 4'h5, 4'h4, OKAY);
        add_entry(OP_RD, 32'h0000_0010, 8'd0, INCR, 32'h0000_0000, 4'h0, 4'h5, OKAY);
        // One aligned 16-byte block for the bursts
        add_entry(OP_WR, 32'h0000_0100, 8'd0, INCR, 32'hA000_0001, 4'hF, 4'h6, OKAY);
        add_entry(OP_WR, 32'h0000_0104, 8'd0, INCR, 32'hA000_0002, 4'hF, 4'h7, OKAY);
        add_entry(OP_WR, 32'h0000_0108, 8'd0, INCR, 32'hA000_0003, 4'hF, 4'h8, OKAY);
        add_entry(OP_WR, 32'h0000_010C, 8'd0, INCR, 32'hA000_0004, 4'hF, 4'h9, OKAY);
        add_entry(OP_RD, 32'h0000_0100, 8'd3, INCR, 32'h0000_0000, 4'h0, 4'hA, OKAY);
        add_entry(OP_RD, 32'h0000_0108, 8'd3, WRAP, 32'h0000_0000, 4'h0, 4'hB, OKAY);
        // 0x1010 aliases the word at 0x010 and must not reach it
        add_entry(OP_WR, 32'h0000_1010, 8'd0, INCR, 32'hBADB_AD00, 4'hF, 4'hC, DECERR);
        add_entry(OP_RD, 32'h0000_0010, 8'd0, INCR, 32'h0000_0000, 4'h0, 4'hD, OKAY);
        add_entry(OP_RD, 32'h0000_1010, 8'd0, INCR, 32'h0000_0000, 4'h0, 4'hE, DECERR);
        add_entry(OP_RD, 32'h0000_0104, 8'd1, WRAP, 32'h0000_0000, 4'h0, 4'hF, OKAY);
        add_entry(OP_WR, 32'h0000_0104, 8'd0, INCR, 32'h5A5A_FFFF, 4'hC, 4'h0, OKAY);
        add_entry(OP_RD, 32'h0000_0100, 8'd3, INCR, 32'h0000_0000, 4'h0, 4'h3, OKAY);
    endtask

    task automatic drive_idle();
        awvalid = 1'b0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = 3'd2;
        awburst = INCR;
        awid    = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arlen   = '0;
        arsize  = 3'd2;
        arburst = INCR;
        arid    = '0;
        rready  = 1'b0;
    endtask

    function automatic logic pick_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    function automatic axi_data_t merge_strobes(input axi_data_t old_word,
                                                input axi_data_t new_word,
                                                input axi_strb_t strb);
        axi_data_t merged;
        merged = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    // A wrap burst stays inside an aligned block of len + 1 words
    function automatic axi_addr_t next_beat_addr(input axi_addr_t cur, input axi_burst_e burst,
                                                 input axi_len_t len);
        int unsigned block_bytes;
        axi_addr_t   base;
        if (burst != WRAP) begin
            return cur + 32'd4;
        end
        block_bytes = (int'(len) + 1) * 4;
        base = cur - (cur % block_bytes);
        return base + ((cur - base + 32'd4) % block_bytes);
    endfunction

    ////////////////////////////////////////
    // Master transactions
    ////////////////////////////////////////

    task automatic write_word(input axi_addr_t addr, input axi_data_t data,
                              input axi_strb_t strb, input axi_id_t id, input axi_resp_e resp);
        logic      stalled;
        logic      done;
        axi_resp_e held_resp;
        axi_data_t old_word;
        stalled   = 1'b0;
        done      = 1'b0;
        held_resp = OKAY;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        awlen   = '0;
        awburst = INCR;
        awid    = id;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wlast   = 1'b1;
        #1;
        while (!wready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        wvalid = 1'b0;
        wlast  = 1'b0;
        while (!done) begin
            bready = pick_ready();
            #1;
            if (stalled && !bvalid) begin
                $display("bvalid dropped before bready at address %h", addr);
                errors++;
            end
            if (stalled && bvalid && bresp !== held_resp) begin
                $display("Mismatch bresp: expected %h, got %h", held_resp, bresp);
                errors++;
            end
            stalled   = bvalid && !bready;
            held_resp = bresp;
            if (bvalid && bready) begin
                if (bresp !== resp) begin
                    $display("Mismatch bresp: expected %h, got %h", resp, bresp);
                    errors++;
                end
                if (bid !== id) begin
                    $display("Mismatch bid: expected %h, got %h", id, bid);
                    errors++;
                end
                done = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        bready = 1'b0;
        // Only accepted writes reach the RAM
        if (resp == OKAY) begin
            old_word = model.exists(addr) ? model[addr] : '0;
            model[addr] = merge_strobes(old_word, data, strb);
        end
    endtask

    task automatic read_burst(input axi_addr_t addr, input axi_len_t len,
                              input axi_burst_e burst, input axi_id_t id, input axi_resp_e resp);
        axi_addr_t cur;
        int        beat;
        logic      stalled;
        logic      done;
        axi_data_t held_data;
        logic      held_last;
        axi_id_t   held_id;
        cur       = addr;
        beat      = 0;
        stalled   = 1'b0;
        done      = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        held_id   = '0;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        arlen   = len;
        arburst = burst;
        arid    = id;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!done) begin
            rready = pick_ready();
            #1;
            // A stalled beat must come back unchanged
            if (stalled) begin
                if (!rvalid) begin
                    $display("rvalid dropped while rready was low at address %h", cur);
                    errors++;
                end
                if (rdata !== held_data) begin
                    $display("Mismatch rdata: expected %h, got %h", held_data, rdata);
                    errors++;
                end
                if (rlast !== held_last) begin
                    $display("Mismatch rlast: expected %h, got %h", held_last, rlast);
                    errors++;
                end
                if (rid !== held_id) begin
                    $display("Mismatch rid: expected %h, got %h", held_id, rid);
                    errors++;
                end
            end
            stalled   = rvalid && !rready;
            held_data = rdata;
            held_last = rlast;
            held_id   = rid;
            if (rvalid && rready) begin
                if (rresp !== resp) begin
                    $display("Mismatch rresp: expected %h, got %h", resp, rresp);
                    errors++;
                end
                if (rid !== id) begin
                    $display("Mismatch rid: expected %h, got %h", id, rid);
                    errors++;
                end
                if (rlast !== (beat == int'(len))) begin
                    $display("Mismatch rlast: expected %h, got %h", beat == int'(len), rlast);
                    errors++;
                end
                if (resp == OKAY && !model.exists(cur)) begin
                    $display("Read of address %h that was never written", cur);
                    errors++;
                end else if (resp == OKAY && rdata !== model[cur]) begin
                    $display("Mismatch rdata: expected %h, got %h at %h", model[cur], rdata, cur);
                    errors++;
                end
                if (beat == int'(len)) begin
                    done = 1'b1;
                end else begin
                    cur = next_beat_addr(cur, burst, len);
                    beat++;
                end
            end
            if (!done) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        int idx;
        drive_idle();
        rst_n = 1'b1;
        load_tests();
        repeat (3) @(negedge clk);
        rst_n = 1'b0;
        #1;
        if (awready || wready || arready || bvalid || rvalid) begin
            $display("Handshake outputs are not low after reset");
            errors++;
        end
        for (idx = 0; idx < num_loaded; idx++) begin
            if (tests[idx].is_write) begin
                write_word(tests[idx].addr, tests[idx].data, tests[idx].strb,
                           tests[idx].id, tests[idx].resp);
            end else begin
                read_burst(tests[idx].addr, tests[idx].len, tests[idx].burst,
                           tests[idx].id, tests[idx].resp);
            end
        end
        repeat (2) @(negedge clk);
        $display("Ran %0d table entries with %0d errors", num_loaded, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Generous bound of 300 cycles per table entry
    initial begin
        #(NUM_ENTRIES * 300 * CLK_PERIOD);
        $display("Timeout after %0d cycles with the table not finished", NUM_ENTRIES * 300);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
src/axi_pkg.sv
src/mem_1rwm.sv
src/axi_burst_addr.sv
src/axi_bram.sv
src/axi_bram_top.sv
tb/axi_bram_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI block RAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module axi_bram_tb -f build.f -o axi_bram_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/axi_bram_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation log holds no final verdict"
    exit 1
fi

exit 0
